// File: include/exe_macros.svh
`ifndef EXE_MACROS_SVH
`define EXE_MACROS_SVH

// datapath widths
`define EXE_WORD_W      32
`define EXE_REG_ADDR_W  5

// partial products per mult, one per cycle
`define EXE_MUL_CYCLES  32

// exception codes carried to memory
`define EXE_EXC_NONE    5'h00
`define EXE_EXC_ADEL    5'h04
`define EXE_EXC_ADES    5'h05
`define EXE_EXC_OV      5'h0c

`endif

// File: source/exe_pkg.sv
`include "exe_macros.svh"

package exe_pkg;

    typedef logic [`EXE_WORD_W-1:0]     word_t;
    typedef logic [`EXE_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [4:0]                 exc_code_t;
    typedef logic [3:0]                 byte_en_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL,
        ALU_SRA, ALU_LUI, ALU_MULT
    } alu_op_t;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BGEZ, BR_BGTZ,
        BR_BLEZ, BR_BLTZ, BR_J, BR_JAL, BR_JR
    } branch_type_t;

    typedef enum logic [2:0] {
        MEM_NONE, MEM_LB, MEM_LH, MEM_LW, MEM_SB, MEM_SH, MEM_SW
    } mem_op_t;

    typedef enum logic [1:0] {
        MUL_IDLE, MUL_BUSY, MUL_DONE
    } mul_state_t;

    // decoded instruction handed over by decode
    typedef struct packed {
        word_t        pc;
        word_t        rs_value;
        word_t        rt_value;
        logic [15:0]  imm;
        alu_op_t      alu_op;
        logic [1:0]   imm_src;      // 00 none, 01 zero-extend, 10 sign-extend
        logic         src1_is_sa;   // shift amount from imm[10:6]
        logic         link;         // result is pc + 8
        reg_addr_t    dest;
        logic         gr_we;
        mem_op_t      mem_op;
        branch_type_t btype;
        logic [25:0]  jidx;
        logic         pred_valid;
        logic         pred_taken;
        word_t        pred_target;
        logic         exc;
        exc_code_t    exc_code;
    } issue_bus_t;

    typedef struct packed {
        word_t     pc;
        word_t     result;          // doubles as the memory address
        reg_addr_t dest;
        logic      gr_we;
        mem_op_t   mem_op;
        byte_en_t  byte_en;
        word_t     wdata;
        logic      exc;
        exc_code_t exc_code;
    } mem_bus_t;

    typedef struct packed {
        word_t pc;
        logic  is_branch;
        logic  taken;
        word_t target;
        logic  pred_ok;
    } branch_result_t;

endpackage

// File: source/multiplier.sv
`timescale 1ns/1ps
`include "exe_macros.svh"

module multiplier (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  logic           cancel,
    input  exe_pkg::word_t a,
    input  exe_pkg::word_t b,
    output exe_pkg::word_t product,
    output logic           done
);
    import exe_pkg::*;

    localparam int CNT_W = $clog2(`EXE_MUL_CYCLES);

    mul_state_t       state;
    logic [CNT_W-1:0] count;    // partial products added so far
    word_t            acc;
    word_t            mcand;
    word_t            mplier;

    always_ff @(posedge clk) begin
        if (reset || cancel) begin
            state <= MUL_IDLE;
            count <= '0;
        end else begin
            case (state)
                MUL_IDLE: begin
                    if (start) begin
                        state <= MUL_BUSY;
                        count <= CNT_W'(1);   // bit 0 taken on the start edge
                    end
                end
                MUL_BUSY: begin
                    count <= count + 1'b1;
                    if (count == CNT_W'(`EXE_MUL_CYCLES - 1)) begin
                        state <= MUL_DONE;
                    end
                end
                default: state <= MUL_IDLE;   // done lasts one cycle
            endcase
        end
    end

    // shift-add, low word only
    always_ff @(posedge clk) begin
        if (state == MUL_IDLE && start) begin
            acc    <= b[0] ? a : '0;
            mcand  <= a << 1;
            mplier <= b >> 1;
        end else if (state == MUL_BUSY) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign product = acc;
    assign done    = (state == MUL_DONE);

    // the alu must hold off the next mult until this one has finished
    no_start_busy_a: assert property (@(posedge clk) disable iff (reset)
        start |-> state != MUL_BUSY)
        else $error("multiplier started while busy");

endmodule

// File: source/alu.sv
`timescale 1ns/1ps
`include "exe_macros.svh"

module alu (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  exe_pkg::alu_op_t op,
    input  exe_pkg::word_t   src1,
    input  exe_pkg::word_t   src2,
    output exe_pkg::word_t   result,
    output logic             overflow,
    output logic             ready,
    input  logic             cancel
);
    import exe_pkg::*;

    localparam int MSB = `EXE_WORD_W - 1;

    word_t sum;
    word_t diff;
    word_t product;
    word_t mul_hold;     // product kept while the stage is stalled
    logic  mul_done;
    logic  mul_have;
    logic  is_mult;

    assign is_mult = (op == ALU_MULT);
    assign sum     = src1 + src2;
    assign diff    = src1 - src2;

    multiplier u_multiplier (
        .clk     (clk),
        .reset   (reset),
        .start   (start && is_mult),
        .cancel  (cancel),
        .a       (src1),
        .b       (src2),
        .product (product),
        .done    (mul_done)
    );

    always_ff @(posedge clk) begin
        if (reset || cancel || start) begin
            mul_have <= 1'b0;
        end else if (mul_done) begin
            mul_have <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_done) begin
            mul_hold <= product;
        end
    end

    // a new start means the held product belongs to an older mult
    assign ready = !is_mult || mul_done || (mul_have && !start);

    always_comb begin
        case (op)
            ALU_ADD, ALU_ADDU: result = sum;
            ALU_SUB, ALU_SUBU: result = diff;
            ALU_AND:  result = src1 & src2;
            ALU_OR:   result = src1 | src2;
            ALU_XOR:  result = src1 ^ src2;
            ALU_NOR:  result = ~(src1 | src2);
            ALU_SLT:  result = word_t'($signed(src1) < $signed(src2));
            ALU_SLTU: result = word_t'(src1 < src2);
            ALU_SLL:  result = src2 << src1[4:0];
            ALU_SRL:  result = src2 >> src1[4:0];
            ALU_SRA:  result = word_t'($signed(src2) >>> src1[4:0]);
            ALU_LUI:  result = {src2[15:0], 16'h0000};
            ALU_MULT: result = mul_done ? product : mul_hold;
            default:  result = sum;
        endcase
    end

    // signed overflow, trapping ops only
    always_comb begin
        case (op)
            ALU_ADD: overflow = (src1[MSB] == src2[MSB]) && (sum[MSB] != src1[MSB]);
            ALU_SUB: overflow = (src1[MSB] != src2[MSB]) && (diff[MSB] != src1[MSB]);
            default: overflow = 1'b0;
        endcase
    end

endmodule

// File: source/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  logic                    valid,
    input  exe_pkg::word_t          pc,
    input  exe_pkg::word_t          rs_value,
    input  exe_pkg::word_t          rt_value,
    input  logic [15:0]             imm,
    input  logic [25:0]             jidx,
    input  exe_pkg::branch_type_t   btype,
    input  logic                    pred_valid,
    input  logic                    pred_taken,
    input  exe_pkg::word_t          pred_target,
    output exe_pkg::branch_result_t result,
    output logic                    flush_req
);
    import exe_pkg::*;

    word_t seq_pc;
    word_t target;
    logic  rs_zero;
    logic  rs_neg;
    logic  cond;

    assign seq_pc  = pc + 32'd4;
    assign rs_zero = (rs_value == '0);
    assign rs_neg  = rs_value[$bits(word_t)-1];

    always_comb begin
        case (btype)
            BR_BEQ:  cond = (rs_value == rt_value);
            BR_BNE:  cond = (rs_value != rt_value);
            BR_BGEZ: cond = !rs_neg;
            BR_BGTZ: cond = !rs_neg && !rs_zero;
            BR_BLEZ: cond = rs_neg || rs_zero;
            BR_BLTZ: cond = rs_neg;
            BR_J, BR_JAL, BR_JR: cond = 1'b1;
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        case (btype)
            BR_J, BR_JAL: target = {pc[31:28], jidx, 2'b00};   // region jump
            BR_JR:        target = rs_value;
            BR_NONE:      target = seq_pc;
            default:      target = seq_pc + {{14{imm[15]}}, imm, 2'b00};
        endcase
    end

    always_comb begin
        result.pc        = pc;
        result.is_branch = valid && (btype != BR_NONE);
        result.taken     = valid && cond;
        result.target    = target;
        result.pred_ok   = cond ? (target == pred_target) : !pred_taken;
    end

    // unpredicted taken branches also redirect fetch
    assign flush_req = result.is_branch && (pred_valid ? !result.pred_ok : cond);

endmodule

// File: source/store_align.sv
`timescale 1ns/1ps

module store_align (
    input  exe_pkg::mem_op_t mem_op,
    input  exe_pkg::word_t   addr,
    input  exe_pkg::word_t   rt_value,
    output exe_pkg::byte_en_t byte_en,
    output exe_pkg::word_t   wdata,
    output logic             addr_err_store,
    output logic             addr_err_load
);
    import exe_pkg::*;

    logic half_odd;
    logic word_odd;

    assign half_odd = addr[0];
    assign word_odd = (addr[1:0] != 2'b00);

    always_comb begin
        case (mem_op)
            MEM_SB: begin
                byte_en = byte_en_t'(4'b0001 << addr[1:0]);   // little-endian lane
                wdata   = {4{rt_value[7:0]}};
            end
            MEM_SH: begin
                byte_en = addr[1] ? 4'b1100 : 4'b0011;
                wdata   = {2{rt_value[15:0]}};
            end
            MEM_SW: begin
                byte_en = 4'b1111;
                wdata   = rt_value;
            end
            default: begin
                byte_en = 4'b0000;   // loads and alu ops write nothing
                wdata   = rt_value;
            end
        endcase
    end

    assign addr_err_store = ((mem_op == MEM_SH) && half_odd) || ((mem_op == MEM_SW) && word_odd);
    assign addr_err_load  = ((mem_op == MEM_LH) && half_odd) || ((mem_op == MEM_LW) && word_odd);

endmodule

// File: source/exe_stage.sv
`timescale 1ns/1ps
`include "exe_macros.svh"

module exe_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    input  exe_pkg::issue_bus_t     in_bus,
    output logic                    in_allowin,
    output logic                    out_valid,
    output exe_pkg::mem_bus_t       out_bus,
    input  logic                    out_allowin,
    input  logic                    flush,
    output exe_pkg::branch_result_t branch_out,
    output logic                    br_flush,
    output exe_pkg::reg_addr_t      fwd_dest,
    output exe_pkg::word_t          fwd_result
);
    import exe_pkg::*;

    issue_bus_t ir;
    logic       valid;
    logic       first;        // first cycle of the held instruction
    logic       ready;
    logic       accept;
    word_t      src1;
    word_t      src2;
    word_t      alu_result;
    logic       overflow;
    byte_en_t   byte_en;
    word_t      wdata;
    logic       ades;
    logic       adel;
    logic       exc;
    exc_code_t  exc_code;

    // flush from later stages takes nothing new this cycle
    assign in_allowin = !flush && (!valid || (ready && out_allowin));
    assign accept     = in_valid && in_allowin;
    assign out_valid  = valid && ready && !flush;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid <= 1'b0;
            first <= 1'b0;
        end else begin
            first <= accept;
            if (in_allowin) begin
                valid <= in_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ir <= in_bus;
        end
    end

    // operand select
    always_comb begin
        if (ir.src1_is_sa)   src1 = word_t'(ir.imm[10:6]);
        else if (ir.link)    src1 = ir.pc;
        else                 src1 = ir.rs_value;

        if (ir.link)                 src2 = word_t'(8);   // return address pc + 8
        else if (ir.imm_src == 2'b01) src2 = {16'h0000, ir.imm};
        else if (ir.imm_src == 2'b10) src2 = {{16{ir.imm[15]}}, ir.imm};
        else                         src2 = ir.rt_value;
    end

    alu u_alu (
        .clk      (clk),
        .reset    (reset),
        .start    (valid && first),
        .op       (ir.alu_op),
        .src1     (src1),
        .src2     (src2),
        .result   (alu_result),
        .overflow (overflow),
        .ready    (ready),
        .cancel   (flush)
    );

    branch_unit u_branch_unit (
        .valid       (valid),
        .pc          (ir.pc),
        .rs_value    (ir.rs_value),
        .rt_value    (ir.rt_value),
        .imm         (ir.imm),
        .jidx        (ir.jidx),
        .btype       (ir.btype),
        .pred_valid  (ir.pred_valid),
        .pred_taken  (ir.pred_taken),
        .pred_target (ir.pred_target),
        .result      (branch_out),
        .flush_req   (br_flush)
    );

    store_align u_store_align (
        .mem_op         (ir.mem_op),
        .addr           (alu_result),
        .rt_value       (ir.rt_value),
        .byte_en        (byte_en),
        .wdata          (wdata),
        .addr_err_store (ades),
        .addr_err_load  (adel)
    );

    // exception priority: incoming, Ov, AdES, AdEL
    always_comb begin
        exc = ir.exc || overflow || ades || adel;
        if (ir.exc)        exc_code = ir.exc_code;
        else if (overflow) exc_code = `EXE_EXC_OV;
        else if (ades)     exc_code = `EXE_EXC_ADES;
        else if (adel)     exc_code = `EXE_EXC_ADEL;
        else               exc_code = `EXE_EXC_NONE;
    end

    always_comb begin
        out_bus.pc       = ir.pc;
        out_bus.result   = alu_result;
        out_bus.dest     = ir.dest;
        out_bus.gr_we    = ir.gr_we && !exc;       // excepting instr writes nothing
        out_bus.mem_op   = ir.mem_op;
        out_bus.byte_en  = exc ? 4'b0000 : byte_en;
        out_bus.wdata    = wdata;
        out_bus.exc      = exc;
        out_bus.exc_code = exc_code;
    end

    assign fwd_dest   = (valid && out_bus.gr_we) ? ir.dest : '0;
    assign fwd_result = alu_result;

    reset_quiet_a: assert property (@(posedge clk) reset |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

    // memory stage may sample any cycle while stalled
    hold_stable_a: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_allowin |=> $stable(out_bus))
        else $error("out_bus changed under back-pressure");

endmodule

// File: testbench/exe_tb.sv
`timescale 1ns/1ps
`include "exe_macros.svh"

module exe_tb;
    import exe_pkg::*;

    localparam int WAIT_LIMIT = 4 * `EXE_MUL_CYCLES + 100;

    // expected view of one instruction leaving the stage
    typedef struct packed {
        mem_bus_t       mem;
        branch_result_t br;
        logic           flush;
        logic           is_mult;
    } expect_t;

    logic           clk;
    logic           reset;
    logic           in_valid;
    issue_bus_t     in_bus;
    logic           in_allowin;
    logic           out_valid;
    mem_bus_t       out_bus;
    logic           out_allowin;
    logic           flush;
    branch_result_t branch_out;
    logic           br_flush;
    reg_addr_t      fwd_dest;
    word_t          fwd_result;

    expect_t held[$];    // instruction inside the stage, at most one
    int      checks;
    int      errors;
    int      n_out;
    int      n_flushed;
    int      age;        // cycles since acceptance
    logic    timed_out;
    logic    bp_mode;    // random back-pressure and flush

    exe_stage uut (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_bus      (in_bus),
        .in_allowin  (in_allowin),
        .out_valid   (out_valid),
        .out_bus     (out_bus),
        .out_allowin (out_allowin),
        .flush       (flush),
        .branch_out  (branch_out),
        .br_flush    (br_flush),
        .fwd_dest    (fwd_dest),
        .fwd_result  (fwd_result)
    );

    always #4 clk = ~clk;

    function automatic expect_t exe_ref(input issue_bus_t b);
        expect_t     e;
        word_t       a;
        word_t       c;
        word_t       r;
        word_t       tgt;
        logic [32:0] wide;
        logic        ov;
        logic        cond;
        logic        ades;
        logic        adel;
        a = b.src1_is_sa ? word_t'(b.imm[10:6]) : (b.link ? b.pc : b.rs_value);
        if (b.link) c = 32'd8;
        else if (b.imm_src == 2'b01) c = {16'h0000, b.imm};
        else if (b.imm_src == 2'b10) c = {{16{b.imm[15]}}, b.imm};
        else c = b.rt_value;
        ov = 1'b0;
        wide = '0;
        case (b.alu_op)
            ALU_ADD, ALU_ADDU: wide = {a[31], a} + {c[31], c};
            ALU_SUB, ALU_SUBU: wide = {a[31], a} - {c[31], c};
            default: ;
        endcase
        case (b.alu_op)
            ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU: r = wide[31:0];
            ALU_AND:  r = a & c;
            ALU_OR:   r = a | c;
            ALU_XOR:  r = a ^ c;
            ALU_NOR:  r = ~(a | c);
            ALU_SLT:  r = {31'b0, (a ^ 32'h8000_0000) < (c ^ 32'h8000_0000)};
            ALU_SLTU: r = {31'b0, a < c};
            ALU_SLL:  r = c << a[4:0];
            ALU_SRL:  r = c >> a[4:0];
            ALU_SRA:  r = (c >> a[4:0]) | (c[31] ? ~(32'hffff_ffff >> a[4:0]) : 32'h0);
            ALU_LUI:  r = {c[15:0], 16'h0000};
            ALU_MULT: r = a * c;     // low word only
            default:  r = a + c;
        endcase
        if (b.alu_op == ALU_ADD || b.alu_op == ALU_SUB) ov = (wide[32] != wide[31]);

        case (b.btype)
            BR_BEQ:  cond = (b.rs_value == b.rt_value);
            BR_BNE:  cond = (b.rs_value != b.rt_value);
            BR_BGEZ: cond = !b.rs_value[31];
            BR_BGTZ: cond = !b.rs_value[31] && (b.rs_value != 0);
            BR_BLEZ: cond = b.rs_value[31] || (b.rs_value == 0);
            BR_BLTZ: cond = b.rs_value[31];
            BR_J, BR_JAL, BR_JR: cond = 1'b1;
            default: cond = 1'b0;
        endcase
        case (b.btype)
            BR_J, BR_JAL: tgt = {b.pc[31:28], b.jidx, 2'b00};
            BR_JR:        tgt = b.rs_value;
            BR_NONE:      tgt = b.pc + 32'd4;
            default:      tgt = b.pc + 32'd4 + {{14{b.imm[15]}}, b.imm, 2'b00};
        endcase
        e.br.pc        = b.pc;
        e.br.is_branch = (b.btype != BR_NONE);
        e.br.taken     = cond;
        e.br.target    = tgt;
        e.br.pred_ok   = cond ? (tgt == b.pred_target) : !b.pred_taken;
        e.flush        = e.br.is_branch && (b.pred_valid ? !e.br.pred_ok : cond);

        case (b.mem_op)
            MEM_SB: e.mem.byte_en = 4'b0001 << r[1:0];
            MEM_SH: e.mem.byte_en = r[1] ? 4'b1100 : 4'b0011;
            MEM_SW: e.mem.byte_en = 4'b1111;
            default: e.mem.byte_en = 4'b0000;
        endcase
        case (b.mem_op)
            MEM_SB: e.mem.wdata = {4{b.rt_value[7:0]}};
            MEM_SH: e.mem.wdata = {2{b.rt_value[15:0]}};
            default: e.mem.wdata = b.rt_value;
        endcase
        ades = (b.mem_op == MEM_SH && r[0]) || (b.mem_op == MEM_SW && r[1:0] != 2'b00);
        adel = (b.mem_op == MEM_LH && r[0]) || (b.mem_op == MEM_LW && r[1:0] != 2'b00);

        e.mem.pc     = b.pc;
        e.mem.result = r;
        e.mem.dest   = b.dest;
        e.mem.mem_op = b.mem_op;
        e.mem.exc    = b.exc || ov || ades || adel;
        if (b.exc) e.mem.exc_code = b.exc_code;
        else if (ov) e.mem.exc_code = `EXE_EXC_OV;
        else if (ades) e.mem.exc_code = `EXE_EXC_ADES;
        else if (adel) e.mem.exc_code = `EXE_EXC_ADEL;
        else e.mem.exc_code = `EXE_EXC_NONE;
        e.mem.gr_we = b.gr_we && !e.mem.exc;
        if (e.mem.exc) e.mem.byte_en = 4'b0000;
        e.is_mult = (b.alu_op == ALU_MULT);
        return e;
    endfunction

    function automatic issue_bus_t base_bus();
        issue_bus_t b;
        b             = '0;
        b.pc          = $urandom() & 32'hffff_fffc;
        b.rs_value    = $urandom();
        b.rt_value    = $urandom();
        b.imm         = 16'($urandom());
        b.alu_op      = ALU_ADDU;
        b.dest        = reg_addr_t'($urandom_range(1, 31));
        b.gr_we       = 1'b1;
        b.jidx        = 26'($urandom());
        b.pred_target = $urandom();
        return b;
    endfunction

    function automatic issue_bus_t random_alu();
        issue_bus_t b;
        b = base_bus();
        b.alu_op = alu_op_t'($urandom_range(0, 13));
        if (b.alu_op inside {ALU_SLL, ALU_SRL, ALU_SRA}) b.src1_is_sa = 1'($urandom_range(0, 1));
        else if (b.alu_op == ALU_LUI) b.imm_src = 2'b01;
        else b.imm_src = 2'($urandom_range(0, 2));
        if ($urandom_range(0, 7) == 0) begin   // link value pc + 8
            b.alu_op     = ALU_ADDU;
            b.link       = 1'b1;
            b.imm_src    = 2'b00;
            b.src1_is_sa = 1'b0;
        end
        if ($urandom_range(0, 7) == 0) b.rt_value = b.rs_value;
        return b;
    endfunction

    function automatic issue_bus_t random_branch();
        issue_bus_t b;
        expect_t    e;
        int         kind;
        b = base_bus();
        b.btype = branch_type_t'($urandom_range(1, 9));
        b.gr_we = 1'b0;
        kind = $urandom_range(0, 3);
        if (kind == 0) b.rs_value = '0;
        else if (kind == 1) b.rt_value = b.rs_value;
        if (b.btype == BR_JAL) begin
            b.link  = 1'b1;
            b.gr_we = 1'b1;
            b.dest  = 5'd31;
        end
        e = exe_ref(b);
        kind = $urandom_range(0, 2);   // none, correct, wrong
        if (kind == 1) begin
            b.pred_valid = 1'b1;
            b.pred_taken = e.br.taken;
            if (e.br.taken) b.pred_target = e.br.target;
        end else if (kind == 2) begin
            b.pred_valid  = 1'b1;
            b.pred_taken  = !e.br.taken;
            b.pred_target = e.br.target ^ 32'h10;
        end
        return b;
    endfunction

    function automatic issue_bus_t random_mem(input int off);
        issue_bus_t b;
        b = base_bus();
        b.mem_op   = mem_op_t'($urandom_range(1, 6));
        b.imm_src  = 2'b10;
        b.imm      = {b.imm[15:2], 2'b00};
        b.rs_value = {b.rs_value[31:2], 2'(off)};
        b.gr_we    = (b.mem_op inside {MEM_LB, MEM_LH, MEM_LW});
        return b;
    endfunction

    function automatic issue_bus_t random_exc();
        issue_bus_t b;
        int         kind;
        b = base_bus();
        kind = $urandom_range(0, 4);
        b.alu_op = (kind == 1) ? ALU_SUB : ALU_ADD;
        b.rs_value = 32'h4000_0000 | ($urandom() & 32'h3fff_ffff);
        b.rt_value = 32'h4000_0000 | ($urandom() & 32'h3fff_ffff);
        if (kind == 1) b.rt_value = 32'h8000_0000 | ($urandom() & 32'h3fff_ffff);
        if (kind >= 2) begin
            b.exc      = (kind != 4);
            b.exc_code = exc_code_t'($urandom_range(1, 31));
        end
        if (kind == 3) begin   // misaligned sw behind an incoming exception
            b.alu_op   = ALU_ADDU;
            b.mem_op   = MEM_SW;
            b.imm_src  = 2'b10;
            b.imm      = {b.imm[15:2], 2'b00};
            b.rs_value = {b.rs_value[31:2], 2'b01};
        end
        if (kind == 4) begin   // Ov and AdES together
            b.mem_op   = MEM_SH;
            b.imm_src  = 2'b10;
            b.rs_value = 32'h7fff_fff1;
            b.imm      = 16'h0010;
        end
        return b;
    endfunction

    function automatic issue_bus_t random_mult();
        issue_bus_t b;
        b = base_bus();
        b.alu_op = ALU_MULT;
        return b;
    endfunction

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERROR %0t %s: got %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_out(input expect_t e);
        check_field("out_bus.pc", out_bus.pc, e.mem.pc);
        check_field("out_bus.result", out_bus.result, e.mem.result);
        check_field("out_bus.dest", out_bus.dest, e.mem.dest);
        check_field("out_bus.gr_we", out_bus.gr_we, e.mem.gr_we);
        check_field("out_bus.mem_op", out_bus.mem_op, e.mem.mem_op);
        check_field("out_bus.byte_en", out_bus.byte_en, e.mem.byte_en);
        check_field("out_bus.wdata", out_bus.wdata, e.mem.wdata);
        check_field("out_bus.exc", out_bus.exc, e.mem.exc);
        check_field("out_bus.exc_code", out_bus.exc_code, e.mem.exc_code);
        check_field("fwd_result", fwd_result, e.mem.result);
        check_field("branch_out.pc", branch_out.pc, e.br.pc);
        check_field("branch_out.is_branch", branch_out.is_branch, e.br.is_branch);
        check_field("branch_out.taken", branch_out.taken, e.br.taken);
        check_field("branch_out.target", branch_out.target, e.br.target);
        check_field("branch_out.pred_ok", branch_out.pred_ok, e.br.pred_ok);
        check_field("br_flush", br_flush, e.flush);
    endtask

    // scoreboard, sampled mid-cycle
    always @(negedge clk) begin
        logic      leaving;
        reg_addr_t exp_dest;
        if (!reset) begin
            leaving = out_valid && out_allowin;
            if (held.size() != 0) begin
                age++;
                assert (leaving || !in_allowin) else begin
                    $display("%0t: in_allowin high while the stage holds a stalled instruction",
                             $time);
                    errors++;
                end
                if (held[0].is_mult) begin
                    assert (!(out_valid && age <= `EXE_MUL_CYCLES)) else begin
                        $display("%0t: mult result offered after only %0d cycles", $time, age);
                        errors++;
                    end
                end else begin
                    assert (!(age == 1 && !flush && !out_valid)) else begin
                        $display("%0t: out_valid missing in the cycle after acceptance", $time);
                        errors++;
                    end
                end
            end else begin
                assert (!out_valid) else begin
                    $display("%0t: out_valid high with no instruction in the stage", $time);
                    errors++;
                end
                assert (!br_flush) else begin
                    $display("%0t: br_flush high with no instruction in the stage", $time);
                    errors++;
                end
                assert (flush || in_allowin) else begin
                    $display("%0t: in_allowin low although the stage is empty", $time);
                    errors++;
                end
            end
            exp_dest = (held.size() != 0 && held[0].mem.gr_we) ? held[0].mem.dest : '0;
            check_field("fwd_dest", fwd_dest, exp_dest);

            if (leaving && held.size() != 0) begin
                compare_out(held.pop_front());
                n_out++;
            end else if (flush && held.size() != 0) begin
                held.delete();   // dropped by the flush edge
                n_flushed++;
            end
            if (in_valid && in_allowin) begin
                held.push_back(exe_ref(in_bus));
                age = 0;
            end
        end
    end

    always @(posedge clk) begin
        #1;
        if (bp_mode) begin
            out_allowin = ($urandom_range(0, 3) != 0);
            flush       = ($urandom_range(0, 15) == 0);
        end else begin
            out_allowin = 1'b1;
            flush       = 1'b0;
        end
    end

    task automatic issue(input issue_bus_t b);
        int   waited;
        logic taken;
        if (timed_out) return;
        in_bus   = b;
        in_valid = 1'b1;
        waited   = 0;
        taken    = 1'b0;
        while (!taken && waited < WAIT_LIMIT) begin
            @(negedge clk);
            taken = in_allowin;
            @(posedge clk);
            #1;
            waited++;
        end
        in_valid = 1'b0;
        if (!taken) begin
            $display("timeout: instruction at pc %h was never accepted", b.pc);
            timed_out = 1'b1;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (held.size() != 0 && waited < WAIT_LIMIT && !timed_out) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (held.size() != 0 && !timed_out) begin
            $display("timeout: the stage never passed on its last instruction");
            timed_out = 1'b1;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic report(input int num, input string name, input int err_before);
        $display("[%0d] %s finished, %0d errors", num, name, errors - err_before);
    endtask

    initial begin
        int i;
        int err0;
        int pick;
        clk         = 1'b0;
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_bus      = '0;
        out_allowin = 1'b1;
        flush       = 1'b0;
        bp_mode     = 1'b0;
        timed_out   = 1'b0;
        checks      = 0;
        errors      = 0;
        n_out       = 0;
        n_flushed   = 0;
        age         = 0;
        void'($urandom(32'h92761172));
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        assert (!out_valid && !br_flush && fwd_dest == '0 && in_allowin) else begin
            $display("%0t: stage outputs not in their reset state", $time);
            errors++;
        end
        @(posedge clk);
        #1;

        err0 = errors;
        for (i = 0; i < 200; i++) begin
            issue(random_alu());
            if ($urandom_range(0, 5) == 0) idle(1);
        end
        drain();
        report(1, "alu ops", err0);

        err0 = errors;
        for (i = 0; i < 150; i++) issue(random_branch());
        drain();
        report(2, "branches", err0);

        err0 = errors;
        for (i = 0; i < 120; i++) issue(random_mem(i % 4));
        drain();
        report(3, "loads and stores", err0);

        err0 = errors;
        for (i = 0; i < 60; i++) issue(random_exc());
        drain();
        report(4, "exception priority", err0);

        err0 = errors;
        for (i = 0; i < 20; i++) issue(random_mult());
        drain();
        report(5, "mult", err0);

        err0 = errors;
        bp_mode = 1'b1;
        for (i = 0; i < 150; i++) begin
            pick = $urandom_range(0, 9);
            if (pick == 0) issue(random_mult());
            else if (pick < 4) issue(random_mem(pick));
            else issue(random_alu());
        end
        bp_mode = 1'b0;
        idle(2);
        drain();
        report(6, "back-pressure and flush", err0);

        $display("checks %0d, errors %0d, retired %0d, flushed %0d",
                 checks, errors, n_out, n_flushed);
        if (errors == 0 && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: exe.f
+incdir+include
source/exe_pkg.sv
source/multiplier.sv
source/alu.sv
source/branch_unit.sv
source/store_align.sv
source/exe_stage.sv
testbench/exe_tb.sv

// File: Makefile
TOP = exe_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f exe.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
